// File: Makefile
# Verilator build for the FSMC write decoder

TOOL       := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
TOP        := tb_fsmc_write_decoder
RTL_TOP    := fsmc_write_decoder
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_TEXT  := TEST RESULT: FAIL
PASS_TEXT  := TEST RESULT: PASS

.PHONY: all lint lint_rtl sim clean

all: sim

# lint the testbench together with the design
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# lint the design on its own
lint_rtl:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) fsmc_pkg.sv write_event_if.sv \
		fsmc_strobe_sync.sv region_select.sv write_bus_driver.sv fsmc_write_decoder.sv

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the run is judged from the log only
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fsmc_pkg.sv
package fsmc_pkg;

    // external bus and peripheral side widths
    typedef logic [31:0] fsmc_addr_t;
    typedef logic [31:0] fsmc_data_t;

    // low part of the bus address, seen by peripherals as offset
    typedef logic [15:0] periph_addr_t;

    localparam int MAX_REGIONS = 8;

    // lowest address of each region
    // 0..3 output port groups, 4..7 stepper motors 1..4
    localparam fsmc_addr_t REGION_FIRST [MAX_REGIONS] = '{
        32'h0000_0000,
        32'h0000_0010,
        32'h0000_0020,
        32'h0000_0030,
        32'h0001_0000,
        32'h0002_0000,
        32'h0003_0000,
        32'h0004_0000
    };

    // highest address of each region, inclusive
    localparam fsmc_addr_t REGION_LAST [MAX_REGIONS] = '{
        32'h0000_000f,
        32'h0000_001f,
        32'h0000_002f,
        32'h0000_003f,
        32'h0001_ffff,
        32'h0002_ffff,
        32'h0003_ffff,
        32'h0004_ffff
    };

endpackage

// File: fsmc_strobe_sync.sv
`timescale 1ns/1ps

module fsmc_strobe_sync (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 fsmc_write,
    input  fsmc_pkg::fsmc_addr_t fsmc_write_addr,
    input  fsmc_pkg::fsmc_data_t fsmc_write_data,
    write_event_if.source        evt
);

    // strobe history with the newest sample in bit 0
    // bit 0 may go metastable and stays out of the edge decode
    logic [2:0] write_smp;

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            write_smp <= 3'b000;
        end
        else
        begin
            write_smp <= {write_smp[1:0], fsmc_write};
        end
    end

    // rise when the older sample is low and the newer one high
    assign evt.start = (write_smp[2:1] == 2'b01);

    // fall when the older sample is high and the newer one low
    assign evt.stop = (write_smp[2:1] == 2'b10);

    // address and data are held by the master for the whole strobe
    assign evt.addr = fsmc_write_addr;
    assign evt.data = fsmc_write_data;

endmodule

// File: fsmc_write_decoder.sv
`timescale 1ns/1ps

module fsmc_write_decoder #(
    // 1 .. MAX_REGIONS, keeps the first entries of the table
    parameter int num_regions = fsmc_pkg::MAX_REGIONS
) (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   fsmc_write,
    input  fsmc_pkg::fsmc_addr_t   fsmc_write_addr,
    input  fsmc_pkg::fsmc_data_t   fsmc_write_data,
    output fsmc_pkg::periph_addr_t periph_write_addr,
    output fsmc_pkg::fsmc_data_t   periph_write_data,
    output logic [num_regions-1:0] region_write
);
    import fsmc_pkg::*;

    // write events from the synchroniser to all consumers
    write_event_if evt ();

    // one held flag per region
    logic [num_regions-1:0] region_hit;

    fsmc_strobe_sync u_strobe_sync (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .fsmc_write      (fsmc_write),
        .fsmc_write_addr (fsmc_write_addr),
        .fsmc_write_data (fsmc_write_data),
        .evt             (evt)
    );

    // one selector per table entry
    genvar i;
    generate
        for (i = 0; i < num_regions; i++)
        begin : g_region
            region_select #(
                .region_first (REGION_FIRST[i]),
                .region_last  (REGION_LAST[i])
            ) u_region_select (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .evt       (evt),
                .hit       (region_hit[i])
            );
        end
    endgenerate

    write_bus_driver #(
        .num_regions (num_regions)
    ) u_write_bus_driver (
        .sys_clk           (sys_clk),
        .sys_rst_n         (sys_rst_n),
        .evt               (evt),
        .region_hit        (region_hit),
        .periph_write_addr (periph_write_addr),
        .periph_write_data (periph_write_data),
        .region_write      (region_write)
    );

endmodule

// File: region_select.sv
`timescale 1ns/1ps

module region_select #(
    parameter fsmc_pkg::fsmc_addr_t region_first = 32'h0000_0000,
    parameter fsmc_pkg::fsmc_addr_t region_last  = 32'h0000_000f
) (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    write_event_if.sink evt,
    output logic        hit
);

    logic in_range;

    // inclusive compare on the full bus address
    assign in_range = (evt.addr >= region_first) && (evt.addr <= region_last);

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            hit <= 1'b0;
        end
        else if (evt.start)
        begin
            // flag only goes up for our own range
            if (in_range)
            begin
                hit <= 1'b1;
            end
        end
        else if (evt.stop)
        begin
            // strobe gone, release the select
            hit <= 1'b0;
        end
    end

    // table entry from the top must describe a real range
    range_order_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        region_first <= region_last)
        else $error("region range reversed: first %h last %h", region_first, region_last);

endmodule

// File: sources.f
fsmc_pkg.sv
write_event_if.sv
fsmc_strobe_sync.sv
region_select.sv
write_bus_driver.sv
fsmc_write_decoder.sv
tb_fsmc_write_decoder.sv

// File: tb_fsmc_write_decoder.sv
`timescale 1ns/1ps

module tb_fsmc_write_decoder;
    import fsmc_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int IDX_W        = $clog2(MAX_REGIONS);

    // four cycles with the strobe high, four low
    localparam int WRITE_CYCLES = 8;
    localparam int NUM_RANDOM   = 40;
    localparam int IDLE_CYCLES  = 12;

    // first addresses, last addresses plus two gaps, one unmapped, random
    localparam int NUM_WRITES = MAX_REGIONS + (MAX_REGIONS + 2) + 1 + NUM_RANDOM;

    // generous margin on top of the expected run length
    localparam int WATCHDOG_TIME =
        (NUM_WRITES * WRITE_CYCLES + IDLE_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;

    logic                   sys_clk;
    logic                   sys_rst_n;
    logic                   fsmc_write;
    fsmc_addr_t             fsmc_write_addr;
    fsmc_data_t             fsmc_write_data;
    periph_addr_t           periph_write_addr;
    fsmc_data_t             periph_write_data;
    logic [MAX_REGIONS-1:0] region_write;

    logic [15:0] lfsr_state;
    int          check_count;
    int          error_count;

    fsmc_write_decoder #(
        .num_regions (MAX_REGIONS)
    ) dut0 (
        .sys_clk           (sys_clk),
        .sys_rst_n         (sys_rst_n),
        .fsmc_write        (fsmc_write),
        .fsmc_write_addr   (fsmc_write_addr),
        .fsmc_write_data   (fsmc_write_data),
        .periph_write_addr (periph_write_addr),
        .periph_write_data (periph_write_data),
        .region_write      (region_write)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 16'hb400;
        end
        return next;
    endfunction

    // newest bit lands in the lsb
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // select vector straight from the address table
    function automatic logic [MAX_REGIONS-1:0] expected_select(input fsmc_addr_t addr);
        logic [MAX_REGIONS-1:0] sel;
        sel = '0;
        for (int r = 0; r < MAX_REGIONS; r++)
        begin
            if ((addr >= REGION_FIRST[r[IDX_W-1:0]]) && (addr <= REGION_LAST[r[IDX_W-1:0]]))
            begin
                sel[r[IDX_W-1:0]] = 1'b1;
            end
        end
        return sel;
    endfunction

    task automatic check_outputs(input logic [MAX_REGIONS-1:0] sel,
                                 input periph_addr_t offset,
                                 input fsmc_data_t data,
                                 input string tag);
        check_value(32'(region_write), 32'(sel), {tag, " region_write"});
        check_value(32'(periph_write_addr), 32'(offset), {tag, " periph_write_addr"});
        check_value(periph_write_data, data, {tag, " periph_write_data"});
    endtask

    task automatic report_test(input string name, input int first_errors);
        $display("test %s done, %0d errors", name, error_count - first_errors);
    endtask

    // entered and left just after a falling edge
    task automatic bus_write(input fsmc_addr_t addr, input fsmc_data_t data,
                             input string tag);
        logic [MAX_REGIONS-1:0] sel;
        periph_addr_t           offset;
        sel = expected_select(addr);
        offset = addr[15:0];
        fsmc_write = 1'b1;
        fsmc_write_addr = addr;
        fsmc_write_data = data;
        // edges 1 and 2 leave the outputs alone
        repeat (2) @(negedge sys_clk);
        check_outputs('0, '0, '0, {tag, " before rise edge 3"});
        @(negedge sys_clk);
        check_outputs(sel, offset, data, {tag, " after rise edge 3"});
        @(negedge sys_clk);
        fsmc_write = 1'b0;
        repeat (2) @(negedge sys_clk);
        check_outputs(sel, offset, data, {tag, " before fall edge 3"});
        @(negedge sys_clk);
        check_outputs('0, '0, '0, {tag, " after fall edge 3"});
        @(negedge sys_clk);
    endtask

    task automatic test_reset_state();
        int first_errors;
        first_errors = error_count;
        check_outputs('0, '0, '0, "reset release");
        repeat (2) @(negedge sys_clk);
        check_outputs('0, '0, '0, "idle after reset");
        report_test("reset state", first_errors);
    endtask

    task automatic test_first_addresses();
        logic [31:0] data;
        int          first_errors;
        first_errors = error_count;
        for (int r = 0; r < MAX_REGIONS; r++)
        begin
            take_bits(32, data);
            bus_write(REGION_FIRST[r[IDX_W-1:0]], data, $sformatf("first of region %0d", r));
        end
        report_test("first addresses", first_errors);
    endtask

    task automatic test_boundaries();
        logic [31:0] data;
        int          first_errors;
        first_errors = error_count;
        for (int r = 0; r < MAX_REGIONS; r++)
        begin
            take_bits(32, data);
            bus_write(REGION_LAST[r[IDX_W-1:0]], data, $sformatf("last of region %0d", r));
        end
        // gaps above the port groups and above the last motor
        take_bits(32, data);
        bus_write(REGION_LAST[3] + 32'd1, data, "past region 3");
        take_bits(32, data);
        bus_write(REGION_LAST[7] + 32'd1, data, "past region 7");
        report_test("boundaries", first_errors);
    endtask

    task automatic test_unmapped();
        int first_errors;
        first_errors = error_count;
        bus_write(32'h0000_0200, 32'hcafe_0200, "unmapped 0x200");
        report_test("unmapped", first_errors);
    endtask

    task automatic test_random_writes();
        logic [31:0] pick;
        logic [31:0] offset;
        logic [31:0] data;
        logic [2:0]  region;
        fsmc_addr_t  addr;
        int          first_errors;
        first_errors = error_count;
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            take_bits(4, pick);
            if (pick == 32'd0)
            begin
                // hole between port groups and motors
                take_bits(8, offset);
                addr = 32'h0000_0100 + offset;
            end
            else
            begin
                take_bits(3, pick);
                region = pick[2:0];
                if (region < 3'd4)
                begin
                    take_bits(4, offset);
                end
                else
                begin
                    take_bits(16, offset);
                end
                addr = REGION_FIRST[region] + offset;
            end
            take_bits(32, data);
            bus_write(addr, data, $sformatf("random write %0d", n));
        end
        report_test("random writes", first_errors);
    endtask

    // bus lines wander with the strobe low
    task automatic test_idle_bus();
        logic [31:0] value;
        int          first_errors;
        first_errors = error_count;
        for (int n = 0; n < IDLE_CYCLES; n++)
        begin
            take_bits(32, value);
            fsmc_write_addr = value;
            take_bits(32, value);
            fsmc_write_data = value;
            @(negedge sys_clk);
            check_outputs('0, '0, '0, $sformatf("idle cycle %0d", n));
        end
        report_test("idle bus", first_errors);
    endtask

    initial
    begin
        sys_rst_n = 1'b0;
        fsmc_write = 1'b0;
        fsmc_write_addr = '0;
        fsmc_write_data = '0;
        lfsr_state = 16'd40125;
        check_count = 0;
        error_count = 0;
        repeat (RESET_CYCLES) @(negedge sys_clk);
        sys_rst_n = 1'b1;

        test_reset_state();
        test_first_addresses();
        test_boundaries();
        test_unmapped();
        test_random_writes();
        test_idle_bus();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_TIME);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: write_bus_driver.sv
`timescale 1ns/1ps

module write_bus_driver #(
    parameter int num_regions = fsmc_pkg::MAX_REGIONS
) (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    write_event_if.sink            evt,
    input  logic [num_regions-1:0] region_hit,
    output fsmc_pkg::periph_addr_t periph_write_addr,
    output fsmc_pkg::fsmc_data_t   periph_write_data,
    output logic [num_regions-1:0] region_write
);
    import fsmc_pkg::*;

    // offset and data held for the whole write, zero otherwise
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            periph_write_addr <= '0;
            periph_write_data <= '0;
        end
        else if (evt.start)
        begin
            // latched even for unmapped addresses
            periph_write_addr <= periph_addr_t'(evt.addr);
            periph_write_data <= evt.data;
        end
        else if (evt.stop)
        begin
            periph_write_addr <= '0;
            periph_write_data <= '0;
        end
    end

    // select flags are already registered on the same edge as the payload
    assign region_write = region_hit;

    // overlapping table entries would raise two selects at once
    select_onehot_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $onehot0(region_write))
        else $error("more than one region selected: %b", region_write);

    // edge decode in the synchroniser must never report both edges
    event_exclusive_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(evt.start && evt.stop))
        else $error("start and stop high in the same cycle");

    // selects only move on a write event the cycle before
    select_change_a: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (region_write != $past(region_write)) |-> $past(evt.start || evt.stop))
        else $error("region_write changed without a write event");

endmodule

// File: write_event_if.sv
`timescale 1ns/1ps

interface write_event_if;
    import fsmc_pkg::*;

    // one-cycle pulses on the sampled strobe edges
    logic       start;
    logic       stop;

    // bus address and data, valid while start is high
    fsmc_addr_t addr;
    fsmc_data_t data;

    modport source (
        output start,
        output stop,
        output addr,
        output data
    );

    modport sink (
        input start,
        input stop,
        input addr,
        input data
    );
endinterface
